// File: src/hub75_pkg.sv
// ####################
// hub75 package
// panel geometry, width helpers and shared types
// ####################
package hub75_pkg;

    // single 64x32 panel, scanned as two 16-row halves
    localparam int unsigned PIXEL_WIDTH = 64;
    localparam int unsigned PIXEL_HEIGHT = 32;
    localparam int unsigned PIXEL_HALFHEIGHT = PIXEL_HEIGHT / 2;
    localparam int unsigned COLOR_BITS = 3;

    // cycles from fetch start until the pixel data is usable
    localparam int unsigned FETCH_CYCLES = 3;

    typedef logic [$clog2(PIXEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_addr_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } pixel_rgb_t;

    // host write, y covers the full panel height
    typedef struct packed {
        col_addr_t x;
        logic [$clog2(PIXEL_HEIGHT)-1:0] y;
        pixel_rgb_t color;
    } pixel_write_t;

    typedef enum logic [2:0] {
        SCAN_FETCH,
        SCAN_SHIFT,
        SCAN_BLANK,
        SCAN_LATCH,
        SCAN_DISPLAY
    } scan_state_t;

    // ram address is row bits above column bits
    function automatic int unsigned num_address_b_bits(input int unsigned width,
                                                       input int unsigned halfheight);
        return $clog2(halfheight) + $clog2(width);
    endfunction

    // one word carries a pixel of every scanned half
    function automatic int unsigned num_data_b_bits(input int unsigned height,
                                                    input int unsigned color_bits,
                                                    input int unsigned halfheight);
        return (height / halfheight) * color_bits;
    endfunction

    function automatic int unsigned num_bits_per_subpanel(input int unsigned height,
                                                          input int unsigned color_bits,
                                                          input int unsigned halfheight);
        return num_data_b_bits(height, color_bits, halfheight) / (height / halfheight);
    endfunction

endpackage

// File: src/timeout.sv
// ####################
// timeout counter
// loadable down-counter, running while nonzero
// ####################
`timescale 1ns/1ps

module timeout #(
    parameter int unsigned COUNTER_WIDTH = 2,
    parameter int unsigned LOAD_VALUE = 3
) (
    input  logic reset,
    input  logic clk_in,
    input  logic start,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic running
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // a new start restarts the count
            counter <= COUNTER_WIDTH'(LOAD_VALUE);
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    assign running = (counter != '0);

endmodule

// File: src/framebuffer_ram.sv
// ####################
// framebuffer ram
// dual-port, half-selective write, registered read
// ####################
`timescale 1ns/1ps

module framebuffer_ram
    import hub75_pkg::*;
#(
    parameter int unsigned PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int unsigned PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT,
    parameter int unsigned PIXEL_HALFHEIGHT = hub75_pkg::PIXEL_HALFHEIGHT,
    parameter int unsigned COLOR_BITS = hub75_pkg::COLOR_BITS,
    localparam int unsigned ADDR_BITS = num_address_b_bits(PIXEL_WIDTH, PIXEL_HALFHEIGHT),
    localparam int unsigned DATA_BITS = num_data_b_bits(PIXEL_HEIGHT, COLOR_BITS,
                                                        PIXEL_HALFHEIGHT),
    localparam int unsigned DEPTH = 2 ** ADDR_BITS
) (
    input  logic clk_in,
    input  logic wr_en,
    input  logic [ADDR_BITS-1:0] wr_address,
    input  logic wr_half,
    input  pixel_rgb_t wr_rgb,
    input  logic rd_enable,
    input  logic [ADDR_BITS-1:0] rd_address,
    output logic [DATA_BITS-1:0] rd_data
);

    logic [DATA_BITS-1:0] mem [DEPTH];

    // blank panel until the host writes
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // only the addressed half of the word changes
    always @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_address][wr_half*COLOR_BITS +: COLOR_BITS] <= wr_rgb;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_enable) begin
            rd_data <= mem[rd_address];
        end
    end

endmodule

// File: src/framebuffer_fetch.sv
// ####################
// framebuffer fetch
// reads one ram word and splits it into top and bottom pixels
// ####################
`timescale 1ns/1ps

module framebuffer_fetch
    import hub75_pkg::*;
#(
    parameter int unsigned PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int unsigned PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT,
    parameter int unsigned PIXEL_HALFHEIGHT = hub75_pkg::PIXEL_HALFHEIGHT,
    parameter int unsigned COLOR_BITS = hub75_pkg::COLOR_BITS,
    localparam int unsigned ADDR_BITS = num_address_b_bits(PIXEL_WIDTH, PIXEL_HALFHEIGHT),
    localparam int unsigned DATA_BITS = num_data_b_bits(PIXEL_HEIGHT, COLOR_BITS,
                                                        PIXEL_HALFHEIGHT),
    localparam int unsigned COUNT_BITS = $clog2(FETCH_CYCLES + 1)
) (
    input  logic reset,
    input  logic clk_in,
    input  col_addr_t column_address,
    input  row_addr_t row_address,
    input  logic pixel_load_start,
    input  logic [DATA_BITS-1:0] ram_data_in,
    output logic [ADDR_BITS-1:0] ram_address,
    output logic ram_clk_enable,
    output pixel_rgb_t pixeldata_top,
    output pixel_rgb_t pixeldata_bottom
);

    logic [COUNT_BITS-1:0] load_counter;

    // row above column, same layout as the write side
    assign ram_address = {row_address, column_address};

    // ram read port is clocked only while the load is in flight
    timeout #(
        .COUNTER_WIDTH(COUNT_BITS),
        .LOAD_VALUE   (FETCH_CYCLES)
    ) u_timeout (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (pixel_load_start),
        .counter(load_counter),
        .running(ram_clk_enable)
    );

    // registered ram word is valid one count after the load
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixeldata_top <= '0;
            pixeldata_bottom <= '0;
        end else if (load_counter == COUNT_BITS'(FETCH_CYCLES - 1)) begin
            {pixeldata_bottom, pixeldata_top} <= ram_data_in;
        end
    end

endmodule

// File: src/pixel_write_queue.sv
// ####################
// pixel write queue
// credit-based fifo draining host writes into the ram
// ####################
`timescale 1ns/1ps

module pixel_write_queue
    import hub75_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter int unsigned PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int unsigned PIXEL_HALFHEIGHT = hub75_pkg::PIXEL_HALFHEIGHT,
    localparam int unsigned ADDR_BITS = num_address_b_bits(PIXEL_WIDTH, PIXEL_HALFHEIGHT),
    localparam int unsigned PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1,
    localparam int unsigned COUNT_BITS = $clog2(QUEUE_DEPTH + 1),
    localparam int unsigned ROW_BITS = $clog2(PIXEL_HALFHEIGHT)
) (
    input  logic reset,
    input  logic clk_in,
    input  logic wr_valid,
    input  pixel_write_t wr_pixel,
    output logic credit_return,
    output logic ram_wr_en,
    output logic [ADDR_BITS-1:0] ram_wr_address,
    output logic ram_wr_half,
    output pixel_rgb_t ram_wr_rgb
);

    pixel_write_t slots [QUEUE_DEPTH];
    pixel_write_t head;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic pop;

    // pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // host only writes while it holds a credit, so no full check
    always_ff @(posedge clk_in) begin
        if (wr_valid) begin
            slots[wr_ptr] <= wr_pixel;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // drain one entry per cycle
    assign pop = (count != '0);
    assign head = slots[rd_ptr];

    // credit goes back with the ram write
    assign credit_return = pop;
    assign ram_wr_en = pop;

    // y msb picks the half, low bits give the scan row
    assign ram_wr_half = head.y[ROW_BITS];
    assign ram_wr_address = {head.y[ROW_BITS-1:0], head.x};
    assign ram_wr_rgb = head.color;

endmodule

// File: src/scan_controller.sv
// ####################
// scan controller
// sequences fetch, shift, blank, latch and display per row
// ####################
`timescale 1ns/1ps

module scan_controller
    import hub75_pkg::*;
#(
    parameter int unsigned DISPLAY_CYCLES = 64,
    parameter int unsigned PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    localparam int unsigned CYCLE_BITS = (DISPLAY_CYCLES > FETCH_CYCLES) ?
                                         $clog2(DISPLAY_CYCLES) : $clog2(FETCH_CYCLES)
) (
    input  logic reset,
    input  logic clk_in,
    input  pixel_rgb_t pixeldata_top,
    input  pixel_rgb_t pixeldata_bottom,
    output col_addr_t column_address,
    output row_addr_t row_address,
    output logic pixel_load_start,
    output logic panel_clk,
    output pixel_rgb_t rgb_top,
    output pixel_rgb_t rgb_bottom,
    output logic latch,
    output logic oe_n,
    output row_addr_t row_out
);

    scan_state_t state;
    logic [CYCLE_BITS-1:0] cycle_cnt;
    logic last_column;
    logic fetch_done;
    logic display_done;

    assign last_column = (column_address == col_addr_t'(PIXEL_WIDTH - 1));
    assign fetch_done = (cycle_cnt == CYCLE_BITS'(FETCH_CYCLES - 1));
    assign display_done = (cycle_cnt == CYCLE_BITS'(DISPLAY_CYCLES - 1));

    // column_address and row_address are the scan counters themselves
    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= SCAN_FETCH;
            cycle_cnt <= '0;
            column_address <= '0;
            row_address <= '0;
            // first latch then shows row 0
            row_out <= '1;
        end else begin
            case (state)
                SCAN_FETCH: begin
                    if (fetch_done) begin
                        cycle_cnt <= '0;
                        state <= SCAN_SHIFT;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                SCAN_SHIFT: begin
                    if (last_column) begin
                        column_address <= '0;
                        state <= SCAN_BLANK;
                    end else begin
                        column_address <= column_address + 1'b1;
                        state <= SCAN_FETCH;
                    end
                end
                SCAN_BLANK: begin
                    // row drivers switch while the panel is dark
                    row_out <= row_address;
                    state <= SCAN_LATCH;
                end
                SCAN_LATCH: begin
                    row_address <= row_address + 1'b1;
                    cycle_cnt <= '0;
                    state <= SCAN_DISPLAY;
                end
                SCAN_DISPLAY: begin
                    if (display_done) begin
                        cycle_cnt <= '0;
                        state <= SCAN_FETCH;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: begin
                    cycle_cnt <= '0;
                    state <= SCAN_FETCH;
                end
            endcase
        end
    end

    // one pulse on entry to each fetch
    assign pixel_load_start = (state == SCAN_FETCH) && (cycle_cnt == '0);

    assign panel_clk = (state == SCAN_SHIFT);
    assign latch = (state == SCAN_LATCH);
    assign oe_n = (state != SCAN_DISPLAY);

    // fetch output only changes at the end of the next fetch,
    // so it already holds through shift and beyond
    assign rgb_top = pixeldata_top;
    assign rgb_bottom = pixeldata_bottom;

endmodule

// File: src/hub75_top.sv
// ####################
// hub75 top
// host write queue, framebuffer and scan path for one panel
// ####################
`timescale 1ns/1ps

module hub75_top
    import hub75_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter int unsigned DISPLAY_CYCLES = 64,
    parameter int unsigned PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int unsigned PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT,
    parameter int unsigned PIXEL_HALFHEIGHT = hub75_pkg::PIXEL_HALFHEIGHT,
    parameter int unsigned COLOR_BITS = hub75_pkg::COLOR_BITS,
    localparam int unsigned ADDR_BITS = num_address_b_bits(PIXEL_WIDTH, PIXEL_HALFHEIGHT),
    localparam int unsigned DATA_BITS = num_data_b_bits(PIXEL_HEIGHT, COLOR_BITS,
                                                        PIXEL_HALFHEIGHT)
) (
    input  logic clk_in,
    input  logic reset,
    input  logic wr_valid,
    input  pixel_write_t wr_pixel,
    output logic credit_return,
    output logic panel_clk,
    output pixel_rgb_t rgb_top,
    output pixel_rgb_t rgb_bottom,
    output logic latch,
    output logic oe_n,
    output row_addr_t row_out
);

    // write side
    logic ram_wr_en;
    logic [ADDR_BITS-1:0] ram_wr_address;
    logic ram_wr_half;
    pixel_rgb_t ram_wr_rgb;

    // read side
    logic [ADDR_BITS-1:0] ram_rd_address;
    logic ram_clk_enable;
    logic [DATA_BITS-1:0] ram_rd_data;

    // scan path
    col_addr_t column_address;
    row_addr_t row_address;
    logic pixel_load_start;
    pixel_rgb_t pixeldata_top;
    pixel_rgb_t pixeldata_bottom;

    pixel_write_queue #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)
    ) u_queue (
        .reset         (reset),
        .clk_in        (clk_in),
        .wr_valid      (wr_valid),
        .wr_pixel      (wr_pixel),
        .credit_return (credit_return),
        .ram_wr_en     (ram_wr_en),
        .ram_wr_address(ram_wr_address),
        .ram_wr_half   (ram_wr_half),
        .ram_wr_rgb    (ram_wr_rgb)
    );

    framebuffer_ram #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .COLOR_BITS      (COLOR_BITS)
    ) u_ram (
        .clk_in    (clk_in),
        .wr_en     (ram_wr_en),
        .wr_address(ram_wr_address),
        .wr_half   (ram_wr_half),
        .wr_rgb    (ram_wr_rgb),
        .rd_enable (ram_clk_enable),
        .rd_address(ram_rd_address),
        .rd_data   (ram_rd_data)
    );

    framebuffer_fetch #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .COLOR_BITS      (COLOR_BITS)
    ) u_fetch (
        .reset           (reset),
        .clk_in          (clk_in),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .ram_data_in     (ram_rd_data),
        .ram_address     (ram_rd_address),
        .ram_clk_enable  (ram_clk_enable),
        .pixeldata_top   (pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom)
    );

    scan_controller #(
        .DISPLAY_CYCLES(DISPLAY_CYCLES),
        .PIXEL_WIDTH   (PIXEL_WIDTH)
    ) u_scan (
        .reset           (reset),
        .clk_in          (clk_in),
        .pixeldata_top   (pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .panel_clk       (panel_clk),
        .rgb_top         (rgb_top),
        .rgb_bottom      (rgb_bottom),
        .latch           (latch),
        .oe_n            (oe_n),
        .row_out         (row_out)
    );

endmodule

// File: test/hub75_checker.sv
// ####################
// hub75 checker
// panel and credit protocol assertions
// ####################
`timescale 1ns/1ps

module hub75_checker
    import hub75_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input logic clk_in,
    input logic reset,
    input logic wr_valid,
    input logic credit_return,
    input logic panel_clk,
    input logic latch,
    input logic oe_n,
    input logic pixel_load_start,
    input scan_state_t scan_state
);

    // writes the host has spent and not yet had back
    int unsigned outstanding;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + 32'(wr_valid) - 32'(credit_return);
        end
    end

    latch_without_clock: assert property (@(posedge clk_in) disable iff (reset)
        latch |-> !panel_clk)
        else $error("latch raised together with panel_clk");

    latch_while_dark: assert property (@(posedge clk_in) disable iff (reset)
        latch |-> oe_n)
        else $error("latch raised while the panel is lit");

    credit_bound: assert property (@(posedge clk_in) disable iff (reset)
        outstanding <= QUEUE_DEPTH)
        else $error("more writes outstanding than the queue holds");

    // a write needs a credit that was already back before this cycle
    spend_with_credit: assert property (@(posedge clk_in) disable iff (reset)
        wr_valid |-> outstanding < QUEUE_DEPTH)
        else $error("host wrote without a credit");

    load_on_fetch_entry: assert property (@(posedge clk_in) disable iff (reset)
        pixel_load_start |-> (scan_state == SCAN_FETCH) &&
                             ($past(scan_state) != SCAN_FETCH || $past(reset)))
        else $error("pixel load started outside fetch entry");

endmodule

bind hub75_top hub75_checker #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
) u_checker (
    .clk_in          (clk_in),
    .reset           (reset),
    .wr_valid        (wr_valid),
    .credit_return   (credit_return),
    .panel_clk       (panel_clk),
    .latch           (latch),
    .oe_n            (oe_n),
    .pixel_load_start(pixel_load_start),
    .scan_state      (u_scan.state)
);

// File: test/hub75_tb.sv
// ####################
// hub75 testbench
// host writes, panel capture and frame checks
// ####################
`timescale 1ns/1ps

module hub75_tb
    import hub75_pkg::*;
();

    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned DISPLAY_CYCLES = 64;
    localparam int NUM_ENTRIES = 14;
    localparam int unsigned FRAME_CYCLES = PIXEL_HALFHEIGHT *
                                           (PIXEL_WIDTH * 4 + 2 + DISPLAY_CYCLES);
    localparam int unsigned WRITE_CYCLES = 16 + NUM_ENTRIES * 4 + 64;
    localparam int unsigned WATCHDOG_CYCLES = 3 * FRAME_CYCLES + WRITE_CYCLES;

    logic clk_in = 1'b0;
    logic reset;
    logic wr_valid;
    pixel_write_t wr_pixel;
    logic credit_return;
    logic panel_clk;
    pixel_rgb_t rgb_top;
    pixel_rgb_t rgb_bottom;
    logic latch;
    logic oe_n;
    row_addr_t row_out;

    // stimulus table
    string names [NUM_ENTRIES];
    pixel_write_t writes [NUM_ENTRIES];
    bit do_write [NUM_ENTRIES];
    pixel_rgb_t expected [NUM_ENTRIES];
    int num_entries = 0;

    // panel model, rows 16..31 come from rgb_bottom
    pixel_rgb_t frame [PIXEL_HEIGHT][PIXEL_WIDTH];
    pixel_rgb_t line_top [PIXEL_WIDTH];
    pixel_rgb_t line_bottom [PIXEL_WIDTH];
    int col_cnt = 0;
    int latch_count = 0;
    int scan_errors = 0;
    row_addr_t prev_row;
    // panel lit at least once since the previous latch
    bit lit_seen = 1'b0;

    int credits = 0;
    int credit_pulses = 0;
    int stalls = 0;
    int pass_count = 0;
    int fail_count = 0;
    int seed;

    hub75_top #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .DISPLAY_CYCLES(DISPLAY_CYCLES)
    ) u_dut (
        .clk_in       (clk_in),
        .reset        (reset),
        .wr_valid     (wr_valid),
        .wr_pixel     (wr_pixel),
        .credit_return(credit_return),
        .panel_clk    (panel_clk),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom),
        .latch        (latch),
        .oe_n         (oe_n),
        .row_out      (row_out)
    );

    always #5 clk_in = ~clk_in;

    function automatic void add_entry(input string name, input int x, input int y,
                                      input pixel_rgb_t color, input bit write_it);
        names[num_entries] = name;
        writes[num_entries].x = col_addr_t'(x);
        writes[num_entries].y = 5'(y);
        writes[num_entries].color = write_it ? color : pixel_rgb_t'(3'b000);
        do_write[num_entries] = write_it;
        num_entries++;
    endfunction

    // last write to a coordinate wins, unwritten pixels stay dark
    function automatic void resolve_expected();
        for (int i = 0; i < num_entries; i++) begin
            expected[i] = '0;
            for (int j = 0; j < num_entries; j++) begin
                if (do_write[j] && writes[j].x == writes[i].x && writes[j].y == writes[i].y) begin
                    expected[i] = writes[j].color;
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input int exp_value, input int act_value);
        if (act_value != exp_value) begin
            $display("[ERROR] %s: expected %0h, got %0h", name, exp_value, act_value);
            fail_count++;
        end else begin
            $display("ok      %s", name);
            pass_count++;
        end
    endtask

    // waits for a credit, then drives one write for a cycle
    task automatic send_pixel(input pixel_write_t pixel);
        while (credits == 0) begin
            wr_valid = 1'b0;
            stalls++;
            @(posedge clk_in);
            #1;
        end
        wr_valid = 1'b1;
        wr_pixel = pixel;
        @(posedge clk_in);
        #1;
    endtask

    // credit bookkeeping of the host, on stable values
    always @(negedge clk_in) begin
        if (reset) begin
            credits = QUEUE_DEPTH;
            credit_pulses = 0;
        end else begin
            credits = credits - int'(wr_valid) + int'(credit_return);
            if (credit_return) begin
                credit_pulses++;
            end
            if (credits < 0 || credits > int'(QUEUE_DEPTH)) begin
                $display("host credit count left its range, now %0d", credits);
                fail_count++;
            end
        end
    end

    always @(negedge clk_in) begin : capture
        int row_idx;
        if (reset) begin
            col_cnt = 0;
            latch_count = 0;
            prev_row = '1;
            lit_seen = 1'b0;
        end else begin
            if (!oe_n) begin
                lit_seen = 1'b1;
            end
            if (panel_clk) begin
                if (col_cnt < int'(PIXEL_WIDTH)) begin
                    line_top[col_cnt] = rgb_top;
                    line_bottom[col_cnt] = rgb_bottom;
                end
                col_cnt++;
            end
            if (latch) begin
                row_idx = int'(row_out);
                if (col_cnt != int'(PIXEL_WIDTH)) begin
                    $display("scan order broken, %0d panel clocks before latch of row %0d",
                             col_cnt, row_idx);
                    scan_errors++;
                end
                if (row_out != row_addr_t'(prev_row + 1'b1)) begin
                    $display("scan order broken, row %0d latched after row %0d",
                             row_idx, int'(prev_row));
                    scan_errors++;
                end
                // every row after the first follows a display period
                if (latch_count > 0 && !lit_seen) begin
                    $display("panel never lit before latch of row %0d", row_idx);
                    scan_errors++;
                end
                for (int c = 0; c < int'(PIXEL_WIDTH); c++) begin
                    frame[row_idx][c] = line_top[c];
                    frame[row_idx + int'(PIXEL_HALFHEIGHT)][c] = line_bottom[c];
                end
                prev_row = row_out;
                col_cnt = 0;
                lit_seen = 1'b0;
                latch_count++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        int rnd;
        int sent;
        int target;
        int x;
        int y;
        seed = 70379;
        reset = 1'b1;
        wr_valid = 1'b0;
        wr_pixel = '0;

        add_entry("top_origin", 0, 0, pixel_rgb_t'(3'b100), 1'b1);
        add_entry("top_shared_word", 5, 3, pixel_rgb_t'(3'b101), 1'b1);
        add_entry("bottom_shared_word", 5, 19, pixel_rgb_t'(3'b010), 1'b1);
        add_entry("top_last_corner", 63, 15, pixel_rgb_t'(3'b111), 1'b1);
        add_entry("bottom_last_corner", 63, 31, pixel_rgb_t'(3'b001), 1'b1);
        rnd = $random(seed);
        add_entry("random_top", 17, 7, pixel_rgb_t'(rnd[2:0]), 1'b1);
        rnd = $random(seed);
        add_entry("random_bottom", 40, 22, pixel_rgb_t'(rnd[2:0]), 1'b1);
        add_entry("overwrite_first", 30, 9, pixel_rgb_t'(3'b011), 1'b1);
        add_entry("top_row10", 10, 10, pixel_rgb_t'(3'b110), 1'b1);
        add_entry("overwrite_last", 30, 9, pixel_rgb_t'(3'b100), 1'b1);
        rnd = $random(seed);
        add_entry("random_bottom_row0", 33, 16, pixel_rgb_t'(rnd[2:0]), 1'b1);
        add_entry("unwritten_bottom_half", 10, 26, pixel_rgb_t'(3'b000), 1'b0);
        add_entry("unwritten_top_half", 40, 6, pixel_rgb_t'(3'b000), 1'b0);
        add_entry("unwritten_word", 62, 0, pixel_rgb_t'(3'b000), 1'b0);
        resolve_expected();

        repeat (15) @(posedge clk_in);
        @(negedge clk_in);
        // oe_n, latch, panel_clk, credit_return, row_out
        check_value("reset_state", 'h8f,
                    int'({oe_n, latch, panel_clk, credit_return, row_out}));
        @(posedge clk_in);
        #1;
        reset = 1'b0;

        sent = 0;
        for (int i = 0; i < num_entries; i++) begin
            if (do_write[i]) begin
                send_pixel(writes[i]);
                sent++;
                if (sent == int'(QUEUE_DEPTH)) begin
                    wr_valid = 1'b0;
                    repeat (8) @(posedge clk_in);
                    #1;
                    check_value("burst_credit_pulses", QUEUE_DEPTH, credit_pulses);
                    check_value("credits_after_idle", QUEUE_DEPTH, credits);
                end
            end
        end
        wr_valid = 1'b0;
        // back-to-back writes after the burst never wait on a credit
        check_value("write_stalls", 0, stalls);

        // drain, then let every row be shifted again from the final ram
        while (credits != int'(QUEUE_DEPTH)) begin
            @(posedge clk_in);
        end
        repeat (2) @(posedge clk_in);
        target = latch_count + int'(PIXEL_HALFHEIGHT) + 1;
        while (latch_count < target) begin
            @(posedge clk_in);
        end
        @(negedge clk_in);

        for (int i = 0; i < num_entries; i++) begin
            x = int'(writes[i].x);
            y = int'(writes[i].y);
            check_value($sformatf("%s (%0d,%0d)", names[i], x, y),
                        int'(expected[i]), int'(frame[y][x]));
        end

        if (scan_errors != 0) begin
            $display("scan_order: %0d latches broke the column count, row sequence or display",
                     scan_errors);
            fail_count++;
        end else begin
            $display("ok      scan_order (%0d latches)", latch_count);
            pass_count++;
        end

        $display("%0d checks, %0d passed, %0d failed", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
src/hub75_pkg.sv
src/timeout.sv
src/framebuffer_ram.sv
src/framebuffer_fetch.sv
src/pixel_write_queue.sv
src/scan_controller.sv
src/hub75_top.sv
test/hub75_checker.sv
test/hub75_tb.sv

// File: Makefile
# Verilator build and run of the hub75 testbench

VERILATOR ?= verilator
TOP ?= hub75_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
